// File: verilog/wr_ctrl_pkg.sv
package wr_ctrl_pkg;

    // stream word layout
    localparam int TAG_W = 4;
    localparam int PAYLOAD_W = 128;

    // memory side widths
    // app address is the burst address in units of 8 byte lanes
    localparam int ADDR_W = 23;
    localparam int MEM_ADDR_W = 26;

    // burst and address counters, also the total burst count width
    localparam int COUNT_W = 24;
    // how far data may run ahead of its addresses
    localparam int THROTTLE_W = 5;

    // waveform header fields
    localparam int HDR_ADDR_LSB = 29;
    localparam int HDR_CNT_W = 11;

    // tags carried in the upper nibble of each stream word
    typedef enum logic [TAG_W-1:0] {
        TAG_FILL = 4'd1,
        TAG_WFM  = 4'd2,
        TAG_CKSM = 4'd4
    } tag_e;

    typedef enum logic [3:0] {
        IDLE,
        TST_TAG,
        SYNC_ERR,
        INIT_FILL,
        WRITE_FILL,
        INIT_WFM,
        WRITE_WFM,
        INIT_CKSM,
        WRITE_CKSM,
        WRITE_HDR,
        DONE
    } seq_state_e;

    // counter load request from the sequencer to the burst engine
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_FILL,
        LOAD_WFM,
        LOAD_CKSM
    } load_op_e;

    // tag kept as plain bits so that out-of-sync words can be carried
    typedef struct packed {
        logic [TAG_W-1:0]     tag;
        logic [PAYLOAD_W-1:0] payload;
    } fifo_word_t;

    typedef struct packed {
        logic [COUNT_W-1:0]   total_count;
        logic [PAYLOAD_W-1:0] payload;
    } fill_header_t;

endpackage

// File: verilog/tag_sequencer.sv
module tag_sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            acq_enabled,
    input  logic                            acq_done,
    input  logic                            fifo_empty,
    input  wr_ctrl_pkg::fifo_word_t         fifo_word,
    input  logic [wr_ctrl_pkg::COUNT_W-1:0] calc_total_burst_count,
    input  logic                            segment_done,
    output wr_ctrl_pkg::load_op_e           load_op,
    output logic                            writing,
    output wr_ctrl_pkg::fill_header_t       fill_header,
    output logic                            fill_header_wr_en,
    output logic                            wr_sync_err,
    output logic                            wr_done
);
    import wr_ctrl_pkg::*;

    seq_state_e state;
    seq_state_e next_state;
    logic       acq_done_sync1;
    logic       acq_done_sync2;

    // acq_done comes from the acquisition machine, two flops before use
    always_ff @(posedge clk) begin
        acq_done_sync1 <= acq_done;
        acq_done_sync2 <= acq_done_sync1;
    end

    always_comb begin
        next_state = state;
        case (state)
            // FIFO is fall-through, so not empty means the head word is valid
            IDLE: begin
                if (!fifo_empty) begin
                    next_state = TST_TAG;
                end
            end
            TST_TAG: begin
                case (fifo_word.tag)
                    TAG_FILL: next_state = INIT_FILL;
                    TAG_WFM:  next_state = INIT_WFM;
                    TAG_CKSM: next_state = INIT_CKSM;
                    // lost word alignment in the stream
                    default:  next_state = SYNC_ERR;
                endcase
            end
            // stuck here until reset or enable drop
            SYNC_ERR:   next_state = SYNC_ERR;
            INIT_FILL:  next_state = WRITE_FILL;
            INIT_WFM:   next_state = WRITE_WFM;
            INIT_CKSM:  next_state = WRITE_CKSM;
            WRITE_FILL: begin
                if (segment_done) begin
                    next_state = WRITE_HDR;
                end
            end
            WRITE_WFM, WRITE_CKSM: begin
                if (segment_done) begin
                    next_state = IDLE;
                end
            end
            WRITE_HDR:  next_state = DONE;
            DONE: begin
                if (acq_done_sync2) begin
                    next_state = IDLE;
                end
            end
            default:    next_state = IDLE;
        endcase
    end

    // state register and registered strobes
    always_ff @(posedge clk) begin
        if (reset || !acq_enabled) begin
            state             <= IDLE;
            load_op           <= LOAD_NONE;
            fill_header_wr_en <= 1'b0;
            wr_sync_err       <= 1'b0;
            wr_done           <= 1'b0;
        end else begin
            state <= next_state;
            // load request is valid during the INIT state itself
            case (next_state)
                INIT_FILL: load_op <= LOAD_FILL;
                INIT_WFM:  load_op <= LOAD_WFM;
                INIT_CKSM: load_op <= LOAD_CKSM;
                default:   load_op <= LOAD_NONE;
            endcase
            // push lands one cycle after the header state
            fill_header_wr_en <= (state == WRITE_HDR);
            wr_sync_err       <= (next_state == SYNC_ERR);
            // drops as soon as the synced acq_done is seen
            wr_done           <= (state == DONE) && (next_state == DONE);
        end
    end

    // header payload from the FIFO head while the tag is tested
    // total count appended as the fill segment completes
    always_ff @(posedge clk) begin
        if (state == TST_TAG && fifo_word.tag == TAG_FILL) begin
            fill_header.payload <= fifo_word.payload;
        end
        if (state == WRITE_FILL && segment_done) begin
            fill_header.total_count <= calc_total_burst_count;
        end
    end

    assign writing = (state == WRITE_FILL) || (state == WRITE_WFM) || (state == WRITE_CKSM);

endmodule

// File: verilog/burst_engine.sv
module burst_engine (
    input  logic                               clk,
    input  logic                               reset,
    input  wr_ctrl_pkg::load_op_e              load_op,
    input  logic                               writing,
    input  wr_ctrl_pkg::fifo_word_t            fifo_word,
    input  logic                               fifo_empty,
    input  logic                               wdf_rdy,
    input  logic                               app_rdy,
    output logic                               segment_done,
    output logic                               wdf_wren,
    output logic                               fifo_rd_en,
    output logic                               app_en,
    output logic [wr_ctrl_pkg::MEM_ADDR_W-1:0] app_addr
);
    import wr_ctrl_pkg::*;

    logic [ADDR_W-1:0]     addr_gen;
    logic [COUNT_W-1:0]    addr_cnt;
    logic [COUNT_W-1:0]    burst_cnt;
    logic [COUNT_W-1:0]    seg_len;
    logic [THROTTLE_W-1:0] throttle;
    logic                  data_accept;
    logic                  addr_accept;
    logic                  addr_cnt_zero;
    logic                  burst_cnt_zero;
    logic                  throttle_full;

    assign data_accept = wdf_wren && wdf_rdy;
    assign addr_accept = app_en && app_rdy;

    // waveform segment is the header word plus the data bursts it announces
    assign seg_len = COUNT_W'(fifo_word.payload[HDR_CNT_W-1:0]) + COUNT_W'(1);

    // burst address generator
    // fill starts at 0, waveform from its header, checksum just continues
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (load_op == LOAD_FILL) begin
            addr_gen <= '0;
        end else if (load_op == LOAD_WFM) begin
            addr_gen <= fifo_word.payload[HDR_ADDR_LSB +: ADDR_W];
        end else if (addr_accept) begin
            addr_gen <= addr_gen + 1'b1;
        end
    end

    // burst_cnt counts data beats still to send, addr_cnt addresses still to send
    always_ff @(posedge clk) begin
        if (reset) begin
            burst_cnt <= '0;
            addr_cnt  <= '0;
        end else begin
            case (load_op)
                LOAD_FILL, LOAD_CKSM: begin
                    burst_cnt <= COUNT_W'(1);
                    addr_cnt  <= COUNT_W'(1);
                end
                LOAD_WFM: begin
                    burst_cnt <= seg_len;
                    addr_cnt  <= seg_len;
                end
                default: begin
                    if (data_accept) begin
                        burst_cnt <= burst_cnt - 1'b1;
                    end
                    if (addr_accept) begin
                        addr_cnt <= addr_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    assign burst_cnt_zero = (burst_cnt == '0);
    assign addr_cnt_zero  = (addr_cnt == '0);
    assign segment_done   = burst_cnt_zero && addr_cnt_zero;

    // throttle = data beats accepted whose address is not yet accepted
    // a fresh segment always starts balanced
    always_ff @(posedge clk) begin
        if (reset || load_op != LOAD_NONE) begin
            throttle <= '0;
        end else if (data_accept && !addr_accept) begin
            throttle <= throttle + 1'b1;
        end else if (addr_accept && !data_accept) begin
            throttle <= throttle - 1'b1;
        end
    end

    // hold data back before the counter would wrap
    assign throttle_full = &throttle;

    assign wdf_wren   = writing && !fifo_empty && !burst_cnt_zero && !throttle_full;
    // pop the head in the same cycle its beat is taken
    assign fifo_rd_en = data_accept;
    // an address is only offered once its data has gone
    assign app_en     = writing && (throttle != '0) && !addr_cnt_zero;

    // memory side addresses 8 lanes per burst
    assign app_addr = {addr_gen, {(MEM_ADDR_W - ADDR_W){1'b0}}};

endmodule

// File: verilog/ddr3_wr_control.sv
module ddr3_wr_control (
    input  logic                              clk,
    input  logic                              reset,
    // acquisition control and status
    input  logic                              acq_enabled,
    input  logic                              acq_done,
    input  logic [wr_ctrl_pkg::COUNT_W-1:0]   calc_total_burst_count,
    output logic                              wr_sync_err,
    output logic                              wr_done,
    // first-word-fall-through input FIFO
    input  wr_ctrl_pkg::fifo_word_t           fifo_word,
    input  logic                              fifo_empty,
    output logic                              fifo_rd_en,
    // memory data channel
    output logic                              wdf_wren,
    output logic [wr_ctrl_pkg::PAYLOAD_W-1:0] wdf_data,
    input  logic                              wdf_rdy,
    // memory address channel
    output logic                              app_en,
    output logic [wr_ctrl_pkg::MEM_ADDR_W-1:0] app_addr,
    input  logic                              app_rdy,
    // fill-header FIFO write side
    output wr_ctrl_pkg::fill_header_t         fill_header,
    output logic                              fill_header_wr_en
);
    import wr_ctrl_pkg::*;

    load_op_e load_op;
    logic     writing;
    logic     segment_done;

    // data beats come straight off the FIFO head, tag stripped
    assign wdf_data = fifo_word.payload;

    tag_sequencer i_tag_sequencer (
        .clk                    (clk),
        .reset                  (reset),
        .acq_enabled            (acq_enabled),
        .acq_done               (acq_done),
        .fifo_empty             (fifo_empty),
        .fifo_word              (fifo_word),
        .calc_total_burst_count (calc_total_burst_count),
        .segment_done           (segment_done),
        .load_op                (load_op),
        .writing                (writing),
        .fill_header            (fill_header),
        .fill_header_wr_en      (fill_header_wr_en),
        .wr_sync_err            (wr_sync_err),
        .wr_done                (wr_done)
    );

    burst_engine i_burst_engine (
        .clk          (clk),
        .reset        (reset),
        .load_op      (load_op),
        .writing      (writing),
        .fifo_word    (fifo_word),
        .fifo_empty   (fifo_empty),
        .wdf_rdy      (wdf_rdy),
        .app_rdy      (app_rdy),
        .segment_done (segment_done),
        .wdf_wren     (wdf_wren),
        .fifo_rd_en   (fifo_rd_en),
        .app_en       (app_en),
        .app_addr     (app_addr)
    );

endmodule

// File: verification/wr_ctrl_asserts.sv
module wr_ctrl_asserts (
    input logic clk,
    input logic reset,
    input logic acq_enabled,
    input logic app_en,
    input logic app_rdy,
    input logic wdf_wren,
    input logic wdf_rdy,
    input logic wr_sync_err,
    input logic wr_done
);

    logic [31:0] data_total;
    logic [31:0] addr_total;

    // running totals of accepted beats and addresses since reset
    always_ff @(posedge clk) begin
        if (reset) begin
            data_total <= '0;
            addr_total <= '0;
        end else begin
            data_total <= data_total + {31'd0, wdf_wren && wdf_rdy};
            addr_total <= addr_total + {31'd0, app_en && app_rdy};
        end
    end

    // an address may only follow a beat that is already in
    assert property (@(posedge clk) disable iff (reset)
        (app_en && app_rdy) |-> (addr_total < data_total))
        else $error("address accepted ahead of its data beat");

    // both channels quiet while done or stuck in sync error
    assert property (@(posedge clk) disable iff (reset)
        (wr_done || wr_sync_err) |-> (!app_en && !wdf_wren))
        else $error("channel request while done or in sync error");

    // sync error only clears through reset or enable drop
    assert property (@(posedge clk) disable iff (reset)
        $fell(wr_sync_err) |-> $past(!acq_enabled))
        else $error("sync error cleared without reset");

endmodule

bind ddr3_wr_control wr_ctrl_asserts i_wr_ctrl_asserts (.*);

// File: verification/wr_checker.sv
module wr_checker (
    input logic                              clk,
    input logic                              reset,
    input logic                              app_en,
    input logic                              app_rdy,
    input logic [wr_ctrl_pkg::MEM_ADDR_W-1:0] app_addr,
    input logic                              wdf_wren,
    input logic                              wdf_rdy,
    input logic [wr_ctrl_pkg::PAYLOAD_W-1:0]  wdf_data,
    input wr_ctrl_pkg::fill_header_t         fill_header,
    input logic                              fill_header_wr_en
);
    import wr_ctrl_pkg::*;

    logic [MEM_ADDR_W-1:0] exp_addr_q[$];
    logic [PAYLOAD_W-1:0]  exp_data_q[$];
    fill_header_t          exp_hdr_q[$];
    // beats accepted whose address has not come yet
    logic [PAYLOAD_W-1:0]  got_data_q[$];
    int error_count = 0;
    int writes_seen = 0;
    int headers_seen = 0;

    task automatic expect_write(input logic [MEM_ADDR_W-1:0] addr,
                                input logic [PAYLOAD_W-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic expect_header(input fill_header_t hdr);
        exp_hdr_q.push_back(hdr);
    endtask

    function automatic int pending();
        return exp_addr_q.size() + exp_hdr_q.size();
    endfunction

    // n-th address paired with n-th beat
    task automatic compare_write(input logic [MEM_ADDR_W-1:0] addr,
                                 input logic [PAYLOAD_W-1:0] data);
        logic [MEM_ADDR_W-1:0] ea;
        logic [PAYLOAD_W-1:0]  ed;
        writes_seen++;
        if (exp_addr_q.size() == 0) begin
            error_count++;
            $display("Error at %0t: unexpected write to address %h", $time, addr);
        end else begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            if (addr !== ea || data !== ed) begin
                error_count++;
                $display("Error at %0t: write %h / %h, expected %h / %h",
                         $time, addr, data, ea, ed);
            end
        end
    endtask

    // sampled at the edge, before the DUT registers move
    always @(posedge clk) begin
        if (reset) begin
            got_data_q.delete();
        end else begin
            if (app_en && app_rdy) begin
                if (got_data_q.size() == 0) begin
                    error_count++;
                    $display("Error at %0t: address %h accepted before its data beat",
                             $time, app_addr);
                end else begin
                    compare_write(app_addr, got_data_q.pop_front());
                end
            end
            if (wdf_wren && wdf_rdy) begin
                got_data_q.push_back(wdf_data);
            end
            if (fill_header_wr_en) begin
                headers_seen++;
                if (exp_hdr_q.size() == 0) begin
                    error_count++;
                    $display("Error at %0t: unexpected header push", $time);
                end else if (fill_header !== exp_hdr_q[0]) begin
                    error_count++;
                    $display("Error at %0t: header push %h, expected %h",
                             $time, fill_header, exp_hdr_q[0]);
                    void'(exp_hdr_q.pop_front());
                end else begin
                    void'(exp_hdr_q.pop_front());
                end
            end
        end
    end

endmodule

// File: verification/ddr3_wr_control_tb.sv
module ddr3_wr_control_tb;
    import wr_ctrl_pkg::*;

    logic                  clk;
    logic                  reset;
    logic                  acq_enabled;
    logic                  acq_done;
    logic [COUNT_W-1:0]    calc_total_burst_count;
    fifo_word_t            fifo_word;
    logic                  fifo_empty;
    logic                  fifo_rd_en;
    logic                  wdf_wren;
    logic [PAYLOAD_W-1:0]  wdf_data;
    logic                  wdf_rdy;
    logic                  app_en;
    logic [MEM_ADDR_W-1:0] app_addr;
    logic                  app_rdy;
    fill_header_t          fill_header;
    logic                  fill_header_wr_en;
    logic                  wr_sync_err;
    logic                  wr_done;

    // FIFO model, head at index 0
    fifo_word_t        fifo_q[$];
    logic [15:0]       lfsr_state;
    // burst address the next checksum continues from
    logic [ADDR_W-1:0] next_addr;
    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;
    int writes_before;

    ddr3_wr_control i_ddr3_wr_control (.*);
    wr_checker i_wr_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 16 bit Fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // k-th write of a segment lands k bursts past its start, 8 lanes per burst
    function automatic logic [MEM_ADDR_W-1:0] expected_app_addr(input logic [ADDR_W-1:0] start,
                                                                input int index);
        logic [ADDR_W-1:0] burst;
        burst = start + ADDR_W'(index);
        return MEM_ADDR_W'(burst) * MEM_ADDR_W'(8);
    endfunction

    task automatic refresh_fifo();
        fifo_empty = (fifo_q.size() == 0);
        fifo_word  = fifo_empty ? '0 : fifo_q[0];
    endtask

    task automatic push_word(input logic [TAG_W-1:0] tag, input logic [PAYLOAD_W-1:0] payload);
        fifo_word_t w;
        w.tag     = tag;
        w.payload = payload;
        fifo_q.push_back(w);
        refresh_fifo();
    endtask

    // pop on the edge where the beat is taken
    always @(posedge clk) begin
        if (fifo_rd_en && fifo_q.size() > 0) begin
            void'(fifo_q.pop_front());
        end
    end

    // one LFSR bit per ready line each cycle
    always @(negedge clk) begin
        wdf_rdy    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        app_rdy    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        refresh_fifo();
    end

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        int total;
        total = errors + i_wr_checker.error_count;
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // 0 drained, 1 done high, 2 done low, 3 sync error high
    function automatic bit cond_met(input int kind);
        case (kind)
            0:       return fifo_q.size() == 0 && i_wr_checker.pending() == 0;
            1:       return wr_done === 1'b1;
            2:       return wr_done === 1'b0;
            default: return wr_sync_err === 1'b1;
        endcase
    endfunction

    task automatic wait_until(input int kind, input string what);
        int cycles;
        cycles = 0;
        while (!cond_met(kind) && cycles < 4000) begin
            @(negedge clk);
            cycles++;
        end
        if (!cond_met(kind)) begin
            $display("Timeout: %s did not happen within %0d cycles", what, cycles);
            errors++;
            finish_run();
        end
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + i_wr_checker.error_count;
        tests_run++;
        if (total != test_start_errors) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
        test_start_errors = total;
    endtask

    task automatic apply_reset();
        fifo_q.delete();
        refresh_fifo();
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
    endtask

    // send_acq_done raises acq_done once wr_done has held for a while
    task automatic run_fill(input logic [PAYLOAD_W-1:0] payload, input bit send_acq_done);
        i_wr_checker.expect_write(expected_app_addr('0, 0), payload);
        i_wr_checker.expect_header({calc_total_burst_count, payload});
        push_word(TAG_FILL, payload);
        next_addr = ADDR_W'(1);
        wait_until(0, "fill header write and header push");
        wait_until(1, "wr_done rise after the fill header");
        if (send_acq_done) begin
            repeat (8) begin
                @(negedge clk);
                if (!wr_done) begin
                    report_error("wr_done dropped before acq_done");
                end
            end
            acq_done = 1'b1;
            wait_until(2, "wr_done fall after acq_done");
            acq_done = 1'b0;
        end
    endtask

    task automatic run_wfm(input logic [ADDR_W-1:0] start, input int count);
        logic [PAYLOAD_W-1:0] hdr;
        logic [PAYLOAD_W-1:0] data;
        hdr = '0;
        hdr[PAYLOAD_W-1 -: 32] = 32'h5eed_0000 + 32'(count);
        hdr[HDR_ADDR_LSB +: ADDR_W] = start;
        hdr[HDR_CNT_W-1:0] = HDR_CNT_W'(count);
        i_wr_checker.expect_write(expected_app_addr(start, 0), hdr);
        push_word(TAG_WFM, hdr);
        for (int k = 1; k <= count; k++) begin
            data = {4{32'(k) ^ 32'h9e37_79b9 ^ 32'(start)}};
            i_wr_checker.expect_write(expected_app_addr(start, k), data);
            push_word(4'h0, data);
        end
        next_addr = start + ADDR_W'(count) + ADDR_W'(1);
        wait_until(0, "waveform segment writes");
    endtask

    task automatic run_cksm(input logic [PAYLOAD_W-1:0] payload);
        int hdr_before;
        hdr_before = i_wr_checker.headers_seen;
        i_wr_checker.expect_write(expected_app_addr(next_addr, 0), payload);
        push_word(TAG_CKSM, payload);
        next_addr = next_addr + ADDR_W'(1);
        wait_until(0, "checksum write");
        // a header push would land two cycles after the segment ends
        repeat (4) @(negedge clk);
        if (i_wr_checker.headers_seen != hdr_before) begin
            report_error("checksum caused a header push");
        end
    endtask

    initial begin
        reset = 1'b1;
        acq_enabled = 1'b1;
        acq_done = 1'b0;
        calc_total_burst_count = 24'h00_1234;
        wdf_rdy = 1'b0;
        app_rdy = 1'b0;
        fifo_empty = 1'b1;
        fifo_word = '0;
        lfsr_state = 16'd62;
        next_addr = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start_errors = 0;
        apply_reset();

        run_fill(128'h0f11_0000_cafe_0001_0000_0000_1111_2222, 1'b1);
        end_test("fill_header");
        run_wfm(23'h00_1000, 5);
        end_test("waveform_header");
        run_cksm(128'hc0de_0000_0000_0000_0000_0000_0000_0003);
        end_test("checksum");
        // long segment wrapping the burst address, then its checksum
        run_wfm(23'h7f_fff0, 40);
        run_cksm(128'hc0de_0000_0000_0000_0000_0000_0000_0004);
        end_test("back_pressure");

        writes_before = i_wr_checker.writes_seen;
        push_word(4'h7, 128'hdead_beef_0000_0000_0000_0000_0000_0005);
        wait_until(3, "wr_sync_err rise after an unknown tag");
        repeat (20) begin
            @(negedge clk);
            if (!wr_sync_err) begin
                report_error("wr_sync_err dropped before reset");
            end
        end
        if (i_wr_checker.writes_seen != writes_before) begin
            report_error("write accepted after an unknown tag");
        end
        apply_reset();
        if (wr_sync_err) begin
            report_error("wr_sync_err still high after reset");
        end
        run_fill(128'h0f11_0000_cafe_0002_0000_0000_3333_4444, 1'b1);
        end_test("unknown_tag");

        // leave DONE through the enable instead of acq_done
        run_fill(128'h0f11_0000_cafe_0003_0000_0000_5555_6666, 1'b0);
        acq_enabled = 1'b0;
        wait_until(2, "wr_done fall after the enable drop");
        @(negedge clk);
        acq_enabled = 1'b1;
        run_fill(128'h0f11_0000_cafe_0004_0000_0000_7777_8888, 1'b1);
        end_test("enable_drop");

        finish_run();
    end

endmodule

// File: ddr3_wr_control.f
verilog/wr_ctrl_pkg.sv
verilog/tag_sequencer.sv
verilog/burst_engine.sv
verilog/ddr3_wr_control.sv
verification/wr_ctrl_asserts.sv
verification/wr_checker.sv
verification/ddr3_wr_control_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f ddr3_wr_control.f \
		--top-module ddr3_wr_control_tb -Mdir obj_dir
	@out=$$(./obj_dir/Vddr3_wr_control_tb); echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
